// File: design/sdpram_pkg.sv
/* Simple dual-port RAM exerciser shared definitions
   Widths, word types and the write and read port request structs */

package sdpram_pkg;

	// The RAM is 16 words deep
	localparam int ADDR_BITS = 4;

	// One RAM word drives the whole LED bank
	localparam int DATA_BITS = 8;

	localparam int MEM_WORDS = 1 << ADDR_BITS; // Depth follows from the address width

	// The control count only needs to cover the four enable combinations
	localparam int CTRL_BITS = 2;

	// A word address into the RAM
	typedef logic [ADDR_BITS-1:0] addr_t;

	// A RAM word, which is also the value shown on the LEDs
	typedef logic [DATA_BITS-1:0] data_t;

	// Control count whose low bit enables the write and high bit the read
	typedef logic [CTRL_BITS-1:0] ctrl_t;

	// Write port request, 13 bits in all
	typedef struct packed
	{
		logic wen;   // Write the word at the next rising edge
		addr_t waddr; // Word to be written
		data_t wdata; // Value to store
	} wr_req_t;

	// Read port request, 5 bits in all
	typedef struct packed
	{
		logic ren;   // Load the output register at the next rising edge
		addr_t raddr; // Word to be read
	} rd_req_t;

	// Alternating pattern on the LEDs while the board is held in reset
	// It makes a stuck reset easy to spot by eye
	localparam data_t LED_RESET = 8'b10101010;

	// The request structs must stay the widths the ports were sized for
	localparam int WR_REQ_BITS = $bits(wr_req_t); // 1 + ADDR_BITS + DATA_BITS
	localparam int RD_REQ_BITS = $bits(rd_req_t); // 1 + ADDR_BITS

endpackage

// File: design/ram_cmd_gen.sv
/* RAM exerciser command stage
   Steps the address, data and control counters and forms the port requests */

`timescale 1ns/1ps

module ram_cmd_gen #(
	parameter int unsigned WADDR_STEP = 1, // Added to the write address each cycle
	parameter int unsigned WDATA_STEP = 3, // Added to the write data each cycle
	parameter int unsigned RADDR_STEP = 5  // Added to the read address each cycle
) (
	input logic clock,
	input logic resetn,
	output sdpram_pkg::wr_req_t wr_req,
	output sdpram_pkg::rd_req_t rd_req
);

	import sdpram_pkg::*;

	// Steps cut down to the counter widths so the sums wrap naturally
	localparam addr_t WADDR_INC = addr_t'(WADDR_STEP);
	localparam data_t WDATA_INC = data_t'(WDATA_STEP);
	localparam addr_t RADDR_INC = addr_t'(RADDR_STEP);
	localparam ctrl_t CTRL_INC = ctrl_t'(1);

	addr_t waddr_cnt; // Next word to write
	data_t wdata_cnt; // Next value to write
	addr_t raddr_cnt; // Next word to read
	ctrl_t ctrl_cnt;  // Cycles through the four enable patterns

	// Write address walks the RAM at its own stride
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			waddr_cnt <= '0;
		else
			waddr_cnt <= waddr_cnt + WADDR_INC; // Wraps modulo 16
	end

	// Write data steps independently of the address
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			wdata_cnt <= '0;
		else
			wdata_cnt <= wdata_cnt + WDATA_INC; // Wraps modulo 256
	end

	// The read address uses a different stride than the write address
	// With an odd step it still visits every word, just in another order
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			raddr_cnt <= '0;
		else
			raddr_cnt <= raddr_cnt + RADDR_INC;
	end

	// Free-running control count
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			ctrl_cnt <= '0; // Both enables off in reset
		else
			ctrl_cnt <= ctrl_cnt + CTRL_INC;
	end

	// Bit 0 of the control count decides the write port
	// Over four cycles this gives idle, write, read, then write and read together
	assign wr_req.wen = ctrl_cnt[0];
	assign wr_req.waddr = waddr_cnt;
	assign wr_req.wdata = wdata_cnt;

	// Bit 1 of the control count decides the read port
	// On the cycles where both bits are set the ports may hit the same word
	assign rd_req.ren = ctrl_cnt[1];
	assign rd_req.raddr = raddr_cnt;

endmodule

// File: design/sdp_ram_reg.sv
/* Simple dual-port RAM with a registered read port
   One synchronous write port and one synchronous read port on a shared clock */

`timescale 1ns/1ps

module sdp_ram_reg (
	input logic clock,
	input logic resetn,
	input sdpram_pkg::wr_req_t wr_req,
	input sdpram_pkg::rd_req_t rd_req,
	output sdpram_pkg::data_t rdata
);

	import sdpram_pkg::*;

	// Storage array, written and read only on clock edges
	// This shape maps onto a single block RAM on the usual FPGA families
	data_t mem [MEM_WORDS];

	// Write port
	// The new word becomes visible to reads from the following edge on
	always_ff @(posedge clock)
	begin
		if (wr_req.wen)
			mem[wr_req.waddr] <= wr_req.wdata;
	end

	// Read port with its output register
	// Both blocks sample on the same edge and update with nonblocking
	// assignments, so a read of the word being written in that cycle picks
	// up the contents from before the write
	// That read-before-write collision behavior matches a block RAM set to
	// read-first mode
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			rdata <= '0; // LEDs settle to all ones right after reset
		else if (rd_req.ren)
			rdata <= mem[rd_req.raddr];
		// Without a read enable the output register keeps the last word
	end

	// With ADDR_BITS wide addresses every index falls inside the array
	// so no range check is needed on either port

	// Write and read latency are both one cycle
	// A word written at edge k can be read by a request presented after edge k
	// and it lands in rdata at edge k+1 of that request

	// Port activity over one control period, for reference
	//   ctrl 0  neither port
	//   ctrl 1  write only
	//   ctrl 2  read only
	//   ctrl 3  write and read in the same cycle

endmodule

// File: design/led_result.sv
/* RAM exerciser result stage
   Registers the inverted read data onto the active-low LEDs */

`timescale 1ns/1ps

module led_result (
	input logic clock,
	input logic resetn,
	input sdpram_pkg::data_t rdata,
	output sdpram_pkg::data_t leds
);

	import sdpram_pkg::*;

	// The board LEDs light when their pin is driven low, so a set data bit
	// is shown by a low output
	// Registering the LED pins also keeps the RAM read path off the pads

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			leds <= LED_RESET; // Alternating pattern while held in reset
		else
			leds <= ~rdata; // Inverted for active-low drive
	end

	// First edge after release shows all ones, since rdata starts at zero
	// From then on every read appears here one cycle after it reaches rdata

endmodule

// File: design/ram_exerciser.sv
/* Self-running simple dual-port RAM exerciser
   Command generation, RAM access and the LED result register in sequence */

`timescale 1ns/1ps

module ram_exerciser #(
	parameter int unsigned WADDR_STEP = 1, // Write address stride
	parameter int unsigned WDATA_STEP = 3, // Write data increment
	parameter int unsigned RADDR_STEP = 5  // Read address stride
) (
	input logic clock,
	input logic resetn,
	output sdpram_pkg::data_t leds
);

	import sdpram_pkg::*;

	wr_req_t wr_req; // Command stage to RAM write port
	rd_req_t rd_req; // Command stage to RAM read port
	data_t rdata;    // RAM output register to the LED stage

	// Decode stage
	// Chooses what each RAM port does in every cycle
	ram_cmd_gen #(
		.WADDR_STEP(WADDR_STEP),
		.WDATA_STEP(WDATA_STEP),
		.RADDR_STEP(RADDR_STEP)
	) cmd_gen_inst (
		.clock(clock),
		.resetn(resetn),
		.wr_req(wr_req),
		.rd_req(rd_req)
	);

	// Execute stage
	// The memory under test
	sdp_ram_reg ram_inst (
		.clock(clock),
		.resetn(resetn),
		.wr_req(wr_req),
		.rd_req(rd_req),
		.rdata(rdata)
	);

	// Result stage
	// Shows each read word on the board LEDs
	led_result result_inst (
		.clock(clock),
		.resetn(resetn),
		.rdata(rdata),
		.leds(leds)
	);

	// End to end a read request presented after edge k shows on the LEDs
	// after edge k+2, one edge into rdata and one more into leds

endmodule

// File: tests/ram_exerciser_chk.sv
/* Command stage checker
   Concurrent assertions on the enables and the counters of the request generator */

`timescale 1ns/1ps

module ram_exerciser_chk #(
	parameter int unsigned WADDR_STEP = 1, // Must match the bound generator
	parameter int unsigned WDATA_STEP = 3,
	parameter int unsigned RADDR_STEP = 5
) (
	input logic clock,
	input logic resetn,
	input sdpram_pkg::wr_req_t wr_req,
	input sdpram_pkg::rd_req_t rd_req
);

	import sdpram_pkg::*;

	// Control count rebuilt from the two enables, ren is the high bit
	ctrl_t ctrl;
	assign ctrl = {rd_req.ren, wr_req.wen};

	// Neither port may act while the generator is held in reset
	enables_off_in_reset: assert property (@(posedge clock)
		!resetn |-> (!wr_req.wen && !rd_req.ren))
		else $error("Port enable active while resetn is low");

	// Each counter moves by exactly its step, wrapping at its width
	// The first edge after release compares against reset values and is left out
	waddr_steps: assert property (@(posedge clock) disable iff (!resetn)
		$past(resetn) |-> wr_req.waddr == addr_t'($past(wr_req.waddr) + WADDR_STEP))
		else $error("Write address did not advance by its step");

	wdata_steps: assert property (@(posedge clock) disable iff (!resetn)
		$past(resetn) |-> wr_req.wdata == data_t'($past(wr_req.wdata) + WDATA_STEP))
		else $error("Write data did not advance by its step");

	raddr_steps: assert property (@(posedge clock) disable iff (!resetn)
		$past(resetn) |-> rd_req.raddr == addr_t'($past(rd_req.raddr) + RADDR_STEP))
		else $error("Read address did not advance by its step");

	// Control walks 0, 1, 2, 3 and back to 0
	ctrl_counts: assert property (@(posedge clock) disable iff (!resetn)
		$past(resetn) |-> ctrl == ctrl_t'($past(ctrl) + 1))
		else $error("Control count did not increment modulo 4");

endmodule

// Attached to every generator, with its own step parameters
bind ram_cmd_gen ram_exerciser_chk #(
	.WADDR_STEP(WADDR_STEP),
	.WDATA_STEP(WDATA_STEP),
	.RADDR_STEP(RADDR_STEP)
) cmd_chk (
	.clock(clock),
	.resetn(resetn),
	.wr_req(wr_req),
	.rd_req(rd_req)
);

// File: tests/ram_exerciser_tb.sv
/* RAM exerciser testbench
   Runs the self-driven DUT through two resets and checks the LEDs against a model */

`timescale 1ns/1ps

module ram_exerciser_tb;

	import sdpram_pkg::*;

	// Write and read strides equal modulo 16, so the cycle with both ports
	// active reads the very word that is being written
	localparam int unsigned WADDR_STEP = 3;
	localparam int unsigned WDATA_STEP = 5;
	localparam int unsigned RADDR_STEP = 19; // Cut to 4 bits this is 3 again

	localparam int RESET_CYCLES = 5;
	localparam int MIN_RUN = 70; // Long enough for addresses and data to wrap
	localparam int TAIL_CYCLES = 60;
	localparam int MIN_COMPARED = 80;
	localparam int CHECK_TIMEOUT = 400; // Cycles

	logic clock;
	logic resetn;
	data_t leds;

	// Reference model of generator, RAM and LED register
	data_t model_mem [MEM_WORDS];
	bit model_written [MEM_WORDS]; // Word has been written at least once
	data_t model_rdata;
	bit model_rdata_known;
	int unsigned model_edges; // Rising edges since reset release
	int model_collisions;     // Same-word reads of a written word during a write

	int value_errors;
	int timeout_errors;
	int other_errors;
	int compared;
	int skipped;
	integer seed;
	integer rand_val;
	int run_len;
	int second_reset_len;

	data_t exp_leds;
	bit exp_known;

	ram_exerciser #(
		.WADDR_STEP(WADDR_STEP),
		.WDATA_STEP(WDATA_STEP),
		.RADDR_STEP(RADDR_STEP)
	) dut (
		.clock(clock),
		.resetn(resetn),
		.leds(leds)
	);

	// 4 ns period
	always
	begin
		#2 clock = ~clock;
	end

	// Steps the model across one rising edge and returns the LEDs after it
	// known drops to zero when the value traces back to a word never written
	function automatic data_t model_edge(input logic in_reset, output bit known);
		ctrl_t ctrl;
		addr_t waddr;
		data_t wdata;
		addr_t raddr;
		data_t next_leds;
		if (in_reset)
		begin
			model_edges = 0; // Counters clear but the array keeps its words
			model_rdata = '0;
			model_rdata_known = 1'b1;
			known = 1'b1;
			return LED_RESET;
		end
		// Requests as the generator left them after the previous edge
		ctrl = ctrl_t'(model_edges % 4);
		waddr = addr_t'((model_edges * WADDR_STEP) % 16);
		wdata = data_t'((model_edges * WDATA_STEP) % 256);
		raddr = addr_t'((model_edges * RADDR_STEP) % 16);
		next_leds = ~model_rdata; // LED register sees rdata from before this edge
		known = model_rdata_known;
		if (ctrl[1])
		begin
			if (ctrl[0] && waddr == raddr && model_written[raddr])
				model_collisions++;
			// Read first, so a collision returns the earlier contents
			model_rdata = model_mem[raddr];
			model_rdata_known = model_written[raddr];
		end
		if (ctrl[0])
		begin
			model_mem[waddr] = wdata;
			model_written[waddr] = 1'b1;
		end
		model_edges++;
		return next_leds;
	endfunction

	// Compares one LED value and reports a mismatch at once
	task automatic check_data(input string name, input data_t expected, input data_t actual);
		compared++;
		if (actual !== expected)
		begin
			value_errors++;
			$display("FAIL at %0t: %s expected %h, actual %h", $time, name, expected, actual);
		end
	endtask

	// Waits a number of falling edges, where all stimulus changes
	task automatic hold_cycles(input int count);
		for (int i = 0; i < count; i++)
			@(negedge clock);
	endtask

	// Waits until enough LED values have been compared, or gives up
	task automatic wait_for_checks(input int target, input int limit);
		int waited;
		waited = 0;
		while (compared < target && waited < limit)
		begin
			@(posedge clock);
			waited++;
		end
		if (compared < target)
		begin
			timeout_errors++;
			$display("Timed out after %0d cycles with only %0d of %0d LED values compared",
				waited, compared, target);
		end
	endtask

	// Comparison process, one model step per rising edge
	always @(posedge clock)
	begin
		exp_leds = model_edge(!resetn, exp_known); // resetn only moves on falling edges
		#1; // Registers have settled well before the next falling edge
		if (exp_known)
			check_data("leds", exp_leds, leds);
		else
			skipped++;
	end

	initial
	begin
		seed = 32'h611a423e;
		clock = 1'b0;
		resetn = 1'b0;
		value_errors = 0;
		timeout_errors = 0;
		other_errors = 0;
		compared = 0;
		skipped = 0;
		model_edges = 0;
		model_rdata = '0;
		model_rdata_known = 1'b1;
		model_collisions = 0;
		for (int i = 0; i < MEM_WORDS; i++)
		begin
			model_mem[i] = '0;
			model_written[i] = 1'b0; // RAM powers up with unknown contents
		end

		// Random point for the second reset and random length for it
		rand_val = $random(seed);
		run_len = MIN_RUN + (rand_val & 31);
		rand_val = $random(seed);
		second_reset_len = 2 + (rand_val & 3);

		hold_cycles(RESET_CYCLES);
		resetn = 1'b1;
		hold_cycles(run_len);

		// Mid-run reset, the LEDs go back to the reset pattern at once
		resetn = 1'b0;
		hold_cycles(second_reset_len);
		resetn = 1'b1; // Sequence restarts on old RAM contents
		hold_cycles(TAIL_CYCLES);

		wait_for_checks(MIN_COMPARED, CHECK_TIMEOUT);
		@(negedge clock); // Lets the last pending comparison complete

		if (model_collisions == 0)
		begin
			other_errors++;
			$display("No read of a written word ever met a write to the same word");
		end

		$display("Summary: %0d value errors, %0d timeouts, %0d other errors, %0d compared, %0d skipped",
			value_errors, timeout_errors, other_errors, compared, skipped);
		if (value_errors + timeout_errors + other_errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: ram_exerciser.f
design/sdpram_pkg.sv
design/ram_cmd_gen.sv
design/sdp_ram_reg.sv
design/led_result.sv
design/ram_exerciser.sv
tests/ram_exerciser_chk.sv
tests/ram_exerciser_tb.sv

// File: Makefile
# Verilator lint and simulation of the RAM exerciser

VERILATOR  := verilator
TOP        := ram_exerciser_tb
FILELIST   := ram_exerciser.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := *** TEST PASSED ***

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

# Static checks over the whole file list, testbench included
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Rebuilt whenever a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The run counts as passed only when the pass message shows up in its output
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
